// File: design/vit_pkg.sv
package vit_pkg;

    //////////////////////////////
    // Trellis and code constants
    //////////////////////////////

    // Constraint length 4 gives 8 states
    localparam int NUM_STATES = 8;
    localparam int STATE_W    = 3;
    localparam int SYM_W      = 2;

    // Encoder register is {input bit, state}, input bit in the MSB
    // sym[1] is the parity under GEN_0, sym[0] the parity under GEN_1
    localparam logic [STATE_W:0] GEN_0 = 4'b1111;
    localparam logic [STATE_W:0] GEN_1 = 4'b1101;

    //////////////////////////////
    // Metric widths and limits
    //////////////////////////////

    localparam int BM_W = 2;
    localparam int PM_W = 6;

    // Start penalty for every state but 0
    localparam logic [PM_W-1:0] PM_INIT_BAD   = 6'd12;

    // Minimum metric at which all metrics are rebased
    localparam logic [PM_W-1:0] PM_NORM_LIMIT = 6'd32;

    //////////////////////////////
    // Survivor memory
    //////////////////////////////

    localparam int SURV_LEN = 16;
    localparam int WARM_W   = $clog2(SURV_LEN);

    //////////////////////////////
    // Payload types
    //////////////////////////////

    typedef logic [SYM_W-1:0] sym_t;

    // One Hamming distance per expected output pair
    typedef struct packed {
        logic [BM_W-1:0] d11;
        logic [BM_W-1:0] d10;
        logic [BM_W-1:0] d01;
        logic [BM_W-1:0] d00;
    } bm_t;

    // Per-state decision bits plus the best state of this step
    typedef struct packed {
        logic [NUM_STATES-1:0] sel;
        logic [STATE_W-1:0]    best;
    } dec_t;

endpackage

// File: design/vit_pipe_stage.sv
`timescale 1ns/1ns

module vit_pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,

    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     valid_q;
    payload_t data_q;

    // Accept when empty or when the held item leaves this cycle
    assign in_ready  = !valid_q || out_ready;

    assign out_valid = valid_q;
    assign out_data  = data_q;

    // Valid flag follows the input whenever the slot can change
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

endmodule

// File: design/vit_branch_metric.sv
`timescale 1ns/1ns

module vit_branch_metric (
    input  logic          clk,
    input  logic          arst_n,

    input  logic          sym_valid,
    output logic          sym_ready,
    input  vit_pkg::sym_t sym,

    output logic          bm_valid,
    input  logic          bm_ready,
    output vit_pkg::bm_t  bm
);

    import vit_pkg::*;

    bm_t bm_d;

    // Number of differing bits between two symbols
    function automatic logic [BM_W-1:0] hamming(sym_t a, sym_t b);
        sym_t diff;
        diff = a ^ b;
        return BM_W'(diff[1]) + BM_W'(diff[0]);
    endfunction

    //////////////////////////////
    // Decode step
    //////////////////////////////

    // Distance to each of the four possible encoder outputs
    always_comb begin
        bm_d.d00 = hamming(sym, 2'b00);
        bm_d.d01 = hamming(sym, 2'b01);
        bm_d.d10 = hamming(sym, 2'b10);
        bm_d.d11 = hamming(sym, 2'b11);
    end

    // Registered towards the ACS stage
    vit_pipe_stage #(
        .payload_t (bm_t)
    ) u_bm_stage (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (sym_valid),
        .in_ready  (sym_ready),
        .in_data   (bm_d),
        .out_valid (bm_valid),
        .out_ready (bm_ready),
        .out_data  (bm)
    );

endmodule

// File: design/vit_acs.sv
`timescale 1ns/1ns

module vit_acs (
    input  logic         clk,
    input  logic         arst_n,

    input  logic         bm_valid,
    output logic         bm_ready,
    input  vit_pkg::bm_t bm,

    output logic         dec_valid,
    input  logic         dec_ready,
    output vit_pkg::dec_t dec
);

    import vit_pkg::*;

    logic [PM_W-1:0]       pm_q   [NUM_STATES];
    logic [PM_W-1:0]       sum_0  [NUM_STATES];
    logic [PM_W-1:0]       sum_1  [NUM_STATES];
    logic [PM_W-1:0]       new_pm [NUM_STATES];
    logic [NUM_STATES-1:0] sel;
    logic [PM_W-1:0]       min_pm;
    logic [STATE_W-1:0]    best;
    logic                  norm;
    logic                  bm_fire;
    dec_t                  dec_d;

    // Branch metric of the transition from state s under input bit b
    function automatic logic [BM_W-1:0] branch_cost(bm_t m, logic b,
                                                    logic [STATE_W-1:0] s);
        logic [STATE_W:0] enc_reg;
        sym_t             expect_out;
        enc_reg    = {b, s};
        expect_out = {^(enc_reg & GEN_0), ^(enc_reg & GEN_1)};
        case (expect_out)
            2'b00:   return m.d00;
            2'b01:   return m.d01;
            2'b10:   return m.d10;
            default: return m.d11;
        endcase
    endfunction

    //////////////////////////////
    // Add-compare-select
    //////////////////////////////

    // Predecessors of t are {t[1:0], 0} and {t[1:0], 1}, input bit is t[2]
    always_comb begin
        logic [STATE_W-1:0] st;
        logic [STATE_W-1:0] pred_0;
        logic [STATE_W-1:0] pred_1;
        for (int t = 0; t < NUM_STATES; t++) begin
            st       = STATE_W'(t);
            pred_0   = {st[STATE_W-2:0], 1'b0};
            pred_1   = {st[STATE_W-2:0], 1'b1};
            sum_0[t] = pm_q[pred_0] + PM_W'(branch_cost(bm, st[STATE_W-1], pred_0));
            sum_1[t] = pm_q[pred_1] + PM_W'(branch_cost(bm, st[STATE_W-1], pred_1));
            // Ties keep the predecessor ending in 0
            sel[t]    = sum_1[t] < sum_0[t];
            new_pm[t] = sel[t] ? sum_1[t] : sum_0[t];
        end
    end

    // Lowest-index state holding the minimum metric
    always_comb begin
        min_pm = new_pm[0];
        best   = '0;
        for (int t = 1; t < NUM_STATES; t++) begin
            if (new_pm[t] < min_pm) begin
                min_pm = new_pm[t];
                best   = STATE_W'(t);
            end
        end
    end

    assign norm    = min_pm >= PM_NORM_LIMIT;
    assign bm_fire = bm_valid && bm_ready;

    //////////////////////////////
    // Path metric registers
    //////////////////////////////

    // Encoder assumed to start in state 0
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int t = 0; t < NUM_STATES; t++) begin
                pm_q[t] <= (t == 0) ? '0 : PM_INIT_BAD;
            end
        end else if (bm_fire) begin
            for (int t = 0; t < NUM_STATES; t++) begin
                pm_q[t] <= norm ? new_pm[t] - min_pm : new_pm[t];
            end
        end
    end

    assign dec_d.sel  = sel;
    assign dec_d.best = best;

    vit_pipe_stage #(
        .payload_t (dec_t)
    ) u_dec_stage (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (bm_valid),
        .in_ready  (bm_ready),
        .in_data   (dec_d),
        .out_valid (dec_valid),
        .out_ready (dec_ready),
        .out_data  (dec)
    );

endmodule

// File: design/vit_survivor.sv
`timescale 1ns/1ns

module vit_survivor (
    input  logic          clk,
    input  logic          arst_n,

    input  logic          dec_valid,
    output logic          dec_ready,
    input  vit_pkg::dec_t dec,

    output logic          out_valid,
    input  logic          out_ready,
    output logic          out_bit
);

    import vit_pkg::*;

    // Newest decided bit in the LSB, oldest in the MSB
    logic [SURV_LEN-1:0] surv_q [NUM_STATES];
    logic [SURV_LEN-1:0] surv_d [NUM_STATES];
    logic [WARM_W-1:0]   warm_cnt;
    logic                warm_done;
    logic                dec_fire;

    // Take a decision only if the output slot is free or being read
    assign dec_ready = !out_valid || out_ready;
    assign dec_fire  = dec_valid && dec_ready;
    assign warm_done = warm_cnt == WARM_W'(SURV_LEN - 1);

    //////////////////////////////
    // Register exchange
    //////////////////////////////

    always_comb begin
        logic [STATE_W-1:0] st;
        logic [STATE_W-1:0] pred;
        for (int t = 0; t < NUM_STATES; t++) begin
            st        = STATE_W'(t);
            pred      = {st[STATE_W-2:0], dec.sel[t]};
            surv_d[t] = {surv_q[pred][SURV_LEN-2:0], st[STATE_W-1]};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int t = 0; t < NUM_STATES; t++) begin
                surv_q[t] <= '0;
            end
        end else if (dec_fire) begin
            for (int t = 0; t < NUM_STATES; t++) begin
                surv_q[t] <= surv_d[t];
            end
        end
    end

    // Saturates once SURV_LEN-1 decisions have gone in
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            warm_cnt <= '0;
        end else if (dec_fire && !warm_done) begin
            warm_cnt <= warm_cnt + 1'b1;
        end
    end

    //////////////////////////////
    // Output register
    //////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (dec_fire && warm_done) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Oldest bit on the best path
    always_ff @(posedge clk) begin
        if (dec_fire && warm_done) begin
            out_bit <= surv_d[dec.best][SURV_LEN-1];
        end
    end

endmodule

// File: design/vit_decoder.sv
`timescale 1ns/1ns

module vit_decoder (
    input  logic          clk,
    input  logic          arst_n,

    // Received symbols
    input  logic          sym_valid,
    output logic          sym_ready,
    input  vit_pkg::sym_t sym,

    // Decoded bits
    output logic          out_valid,
    input  logic          out_ready,
    output logic          out_bit
);

    import vit_pkg::*;

    logic bm_valid;
    logic bm_ready;
    bm_t  bm;

    logic dec_valid;
    logic dec_ready;
    dec_t dec;

    //////////////////////////////
    // Decode
    //////////////////////////////

    vit_branch_metric u_branch_metric (
        .clk       (clk),
        .arst_n    (arst_n),
        .sym_valid (sym_valid),
        .sym_ready (sym_ready),
        .sym       (sym),
        .bm_valid  (bm_valid),
        .bm_ready  (bm_ready),
        .bm        (bm)
    );

    //////////////////////////////
    // Execute
    //////////////////////////////

    vit_acs u_acs (
        .clk       (clk),
        .arst_n    (arst_n),
        .bm_valid  (bm_valid),
        .bm_ready  (bm_ready),
        .bm        (bm),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .dec       (dec)
    );

    //////////////////////////////
    // Result
    //////////////////////////////

    // Output appears SURV_LEN-1 decisions behind the input
    vit_survivor u_survivor (
        .clk       (clk),
        .arst_n    (arst_n),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .dec       (dec),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_bit   (out_bit)
    );

endmodule

// File: testbench/vit_decoder_asserts.sv
`timescale 1ns/1ns

module vit_decoder_asserts (
    input logic clk,
    input logic arst_n,
    input logic sym_ready,
    input logic out_valid,
    input logic out_ready,
    input logic out_bit
);

    // Failed assertions, summed into the testbench totals
    int fail_count = 0;

    //////////////////////////////
    // Reset behavior
    //////////////////////////////

    out_valid_in_reset: assert property (@(posedge clk) !arst_n |-> !out_valid)
        else begin
            fail_count++;
            $error("out_valid is high while reset is asserted");
        end

    // Input side open right after reset
    sym_ready_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> sym_ready)
        else begin
            fail_count++;
            $error("sym_ready is low in the first cycle after reset");
        end

    //////////////////////////////
    // Output handshake
    //////////////////////////////

    out_held_while_stalled: assert property (@(posedge clk) disable iff (!arst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_bit)))
        else begin
            fail_count++;
            $error("out_valid or out_bit changed while out_ready was low");
        end

endmodule

// File: testbench/tb_vit_decoder.sv
`timescale 1ns/1ns

module tb_vit_decoder;

    import vit_pkg::*;

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 5;
    localparam int SEED         = 32'hf5f5_3be8;
    localparam int READY_LIMIT  = 100;
    localparam int VALID_LIMIT  = 10;
    localparam int DRAIN_LIMIT  = 1000;
    localparam int ERR_SPACING  = 20;
    localparam int ERR_OFFSET   = 10;
    // Two pipe stages fill behind a held output register
    localparam int STALL_SLOTS  = 2;

    logic clk = 1'b0;
    logic arst_n;
    logic sym_valid;
    logic sym_ready;
    sym_t sym;
    logic out_valid;
    logic out_ready;
    logic out_bit;

    int seed       = SEED;
    int ready_seed = SEED ^ 32'h3c3c_a5a5;
    bit bp_mode    = 1'b0;
    int errors     = 0;
    int timeouts   = 0;
    int out_count  = 0;
    int stall_acc  = 0;
    int fail_asrt  = 0;
    bit exp_q[$];

    vit_decoder DUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .sym_valid (sym_valid),
        .sym_ready (sym_ready),
        .sym       (sym),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_bit   (out_bit)
    );

    bind vit_decoder vit_decoder_asserts u_asserts (
        .clk       (clk),
        .arst_n    (arst_n),
        .sym_ready (sym_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_bit   (out_bit)
    );

    always #HALF_PERIOD clk = ~clk;

    //////////////////////////////
    // Reference and checks
    //////////////////////////////

    // Encoder output for input bit b in state st with register {b, st}
    function automatic sym_t encode_ref(input logic b, input logic [STATE_W-1:0] st);
        logic [STATE_W:0] shreg;
        logic             p0;
        logic             p1;
        shreg = {b, st};
        p0    = 1'b0;
        p1    = 1'b0;
        for (int k = 0; k <= STATE_W; k++) begin
            if (GEN_0[k]) begin
                p0 = p0 ^ shreg[k];
            end
            if (GEN_1[k]) begin
                p1 = p1 ^ shreg[k];
            end
        end
        return {p0, p1};
    endfunction

    // Errors in every segment for seg_len 0 and only in odd segments otherwise
    function automatic bit error_due(input int i, input int seg_len);
        if (i % ERR_SPACING != ERR_OFFSET) begin
            return 1'b0;
        end
        if (seg_len == 0) begin
            return 1'b1;
        end
        return (i / seg_len) % 2 == 1;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            errors++;
            $display("ERROR at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    //////////////////////////////
    // Stimulus tasks
    //////////////////////////////

    task automatic apply_reset();
        sym_valid <= 1'b0;
        arst_n    <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        check_value("out_valid", 0, int'(out_valid));
        check_value("sym_ready", 1, int'(sym_ready));
    endtask

    task automatic idle_cycles(input int n);
        sym_valid <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    // Offer one symbol and hold it until it is taken
    task automatic send_symbol(input sym_t s, output bit ok);
        int waited;
        sym_valid <= 1'b1;
        sym       <= s;
        waited = 0;
        ok     = 1'b1;
        do begin
            @(posedge clk);
            waited++;
        end while (!sym_ready && waited < READY_LIMIT);
        if (!sym_ready) begin
            timeouts++;
            ok = 1'b0;
            $display("Timeout at %0t ns: sym_ready stayed low for %0d cycles", $time, waited);
        end
    endtask

    // Warm-up not over yet, so nothing may come out
    task automatic expect_no_output(input int n);
        sym_valid <= 1'b0;
        repeat (n) begin
            @(posedge clk);
            check_value("out_valid", 0, int'(out_valid));
        end
    endtask

    task automatic wait_first_output(output bit ok);
        int waited;
        sym_valid <= 1'b0;
        waited = 0;
        ok     = 1'b1;
        while (!out_valid && waited < VALID_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (!out_valid) begin
            timeouts++;
            ok = 1'b0;
            $display("Timeout at %0t ns: no output after %0d symbols", $time, SURV_LEN);
        end
    endtask

    task automatic finish_stream(input int n_bits);
        int waited;
        sym_valid <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (out_count < n_bits && waited < DRAIN_LIMIT);
        if (out_count < n_bits) begin
            timeouts++;
            $display("Timeout at %0t ns: only %0d of %0d decoded bits arrived",
                     $time, out_count, n_bits);
        end
        // Flush outputs stay inside the decoder
        repeat (8) @(negedge clk);
        check_value("out_count", n_bits, out_count);
        check_value("exp_q.size", SURV_LEN - 1, exp_q.size());
        @(posedge clk);
    endtask

    task automatic run_stream(input int n_bits, input bit inject, input int seg_len,
                              input bit gaps, input bit warm_pause);
        logic [STATE_W-1:0] state;
        logic               b;
        sym_t               s;
        bit                 ok;
        int                 total;
        total = n_bits + SURV_LEN - 1;
        state = '0;
        ok    = 1'b1;
        for (int i = 0; i < total && ok; i++) begin
            if (i < n_bits) begin
                b = 1'($random(seed));
            end else begin
                b = 1'b0;
            end
            s     = encode_ref(b, state);
            state = {b, state[STATE_W-1:1]};
            if (inject && i < n_bits && error_due(i, seg_len)) begin
                s = s ^ (((i / ERR_SPACING) % 2 == 1) ? 2'b01 : 2'b10);
            end
            exp_q.push_back(b);
            if (gaps && $unsigned($random(seed)) % 4 == 0) begin
                idle_cycles(1 + $unsigned($random(seed)) % 3);
            end
            send_symbol(s, ok);
            if (ok && warm_pause && i == SURV_LEN - 2) begin
                expect_no_output(8);
            end
            if (ok && warm_pause && i == SURV_LEN - 1) begin
                wait_first_output(ok);
            end
        end
        sym_valid <= 1'b0;
        if (ok) begin
            finish_stream(n_bits);
        end
    endtask

    //////////////////////////////
    // Output side
    //////////////////////////////

    initial begin
        out_ready <= 1'b1;
        forever begin
            @(posedge clk);
            if (bp_mode) begin
                out_ready <= 1'($random(ready_seed));
            end else begin
                out_ready <= 1'b1;
            end
        end
    end

    // Scoreboard and back-pressure monitor
    always @(posedge clk) begin
        if (!arst_n) begin
            exp_q.delete();
            out_count = 0;
            stall_acc = 0;
        end else begin
            if (out_valid && !out_ready) begin
                if (stall_acc >= STALL_SLOTS) begin
                    check_value("sym_ready", 0, int'(sym_ready));
                end
                if (sym_valid && sym_ready) begin
                    stall_acc++;
                end
            end else begin
                stall_acc = 0;
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("At %0t ns a decoded bit arrived with no input bit left to match",
                             $time);
                end else begin
                    check_value("out_bit", int'(exp_q.pop_front()), int'(out_bit));
                end
                out_count++;
            end
        end
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        sym_valid <= 1'b0;
        sym       <= '0;
        arst_n    <= 1'b0;

        $display("Reset values and a clean stream of 200 bits");
        apply_reset();
        run_stream(200, 1'b0, 0, 1'b0, 1'b0);

        $display("Warm-up length and output count");
        apply_reset();
        run_stream(60, 1'b0, 0, 1'b0, 1'b1);

        $display("One flipped bit every %0d symbols", ERR_SPACING);
        apply_reset();
        run_stream(300, 1'b1, 0, 1'b0, 1'b0);

        $display("Random back-pressure and input gaps");
        bp_mode <= 1'b1;
        apply_reset();
        run_stream(400, 1'b0, 0, 1'b1, 1'b0);
        bp_mode <= 1'b0;

        $display("Long run with clean and noisy segments");
        apply_reset();
        run_stream(2000, 1'b1, 250, 1'b0, 1'b0);

        fail_asrt = DUT.u_asserts.fail_count;
        $display("Checks done: %0d errors, %0d assertion failures, %0d timeouts",
                 errors, fail_asrt, timeouts);
        if (errors == 0 && fail_asrt == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
design/vit_pkg.sv
design/vit_pipe_stage.sv
design/vit_branch_metric.sv
design/vit_acs.sv
design/vit_survivor.sv
design/vit_decoder.sv
testbench/vit_decoder_asserts.sv
testbench/tb_vit_decoder.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_vit_decoder
FILE_LIST = vlog.f
SIM_ARGS  = +verilator+error+limit+1000
LOG       = sim.log
FAIL_MSG  = TEST RESULT: FAIL

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST)
	./obj_dir/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
